// ==== dv/mem_stage_properties.sv ====
`timescale 1ns/1ps

module mem_stage_properties (
    input logic                   clk,
    input logic                   rst,
    input logic                   req_valid,
    input logic                   is_load,
    input logic                   is_store,
    input logic                   exception,
    input logic                   done,
    input mem_stage_pkg::dm_sel_t dm_sel,
    input mem_stage_pkg::word_t   vaddr,
    input logic                   wb_cyc,
    input logic                   wb_stb,
    input logic                   wb_we,
    input logic                   wb_ack,
    input mem_stage_pkg::word_t   wb_adr,
    input mem_stage_pkg::word_t   wb_dat_w,
    input mem_stage_pkg::wstrb_t  wb_sel
);
    import mem_stage_pkg::*;

    int unsigned fail_count = 0;
    logic        started = 1'b0;
    wstrb_t      exp_sel;

    always @(posedge clk) started <= 1'b1;

    always_comb begin
        exp_sel = 4'b0000;
        case (dm_sel)
            DM_SB:   exp_sel[vaddr[1:0]] = 1'b1;
            DM_SH:   exp_sel = {{2{vaddr[1]}}, {2{!vaddr[1]}}};
            default: exp_sel = 4'b1111;
        endcase
    end

    reset_quiet: assert property (@(posedge clk)
        started && $past(rst) |-> !done && !wb_cyc && !wb_stb && !wb_we) else begin
        $error("done or bus strobes active during or right after reset");
        fail_count++;
    end

    stb_follows_cyc: assert property (@(posedge clk) disable iff (rst)
        wb_stb == wb_cyc) else begin
        $error("wb_stb differs from wb_cyc");
        fail_count++;
    end

    bus_hold: assert property (@(posedge clk) disable iff (rst)
        wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_sel) &&
                              $stable(wb_we) && $stable(wb_dat_w)) else begin
        $error("bus cycle outputs changed before wb_ack");
        fail_count++;
    end

    phys_addr: assert property (@(posedge clk) disable iff (rst)
        wb_cyc |-> wb_adr == (vaddr & 32'h1fff_ffff)) else begin
        $error("wb_adr is not the translated address");
        fail_count++;
    end

    // stores write with the size rule and loads never write
    store_lanes: assert property (@(posedge clk) disable iff (rst)
        wb_cyc |-> wb_we == is_store && (!is_store || wb_sel == exp_sel)) else begin
        $error("wrong wb_we or wb_sel for the access");
        fail_count++;
    end

    // long enough to see a fill started by the cache
    no_access_no_bus: assert property (@(posedge clk) disable iff (rst)
        $rose(req_valid) && (exception || !(is_load || is_store)) |->
            !wb_cyc ##1 !wb_cyc ##1 !wb_cyc) else begin
        $error("bus cycle for a request that makes no access");
        fail_count++;
    end

    exc_done: assert property (@(posedge clk) disable iff (rst)
        $rose(req_valid) && exception |=> done) else begin
        $error("done not one cycle after an excepted request");
        fail_count++;
    end

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done) else begin
        $error("done held longer than one cycle");
        fail_count++;
    end

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;   // 10 ns period
        end
    end

endmodule

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
    import mem_stage_pkg::*;

    localparam int ROUNDS     = 8;
    localparam int OPS        = 18;   // per round
    localparam int TIMEOUT_NS = (ROUNDS * OPS * 40 + 20) * 10;

    logic       clk;
    logic       rst;
    logic       req_valid, is_load, is_store, overflow, prior_exc, interrupt;
    dm_sel_t    dm_sel;
    word_t      vaddr, wdata, pc;
    exc_code_t  prior_code, exc_code;
    logic       done, exception, wb_cyc, wb_stb, wb_we, wb_ack;
    word_t      badvaddr, rdata, wb_adr, wb_dat_w, wb_dat_r;
    wstrb_t     wb_sel;
    logic [1:0] ack_delay = 2'd0;

    logic [31:0] lfsr_state = 32'hab0b0c33;
    word_t       shadow [256];
    int          bus_cycles = 0;
    int          wait_cycles;
    int          bus_used;

    tb_clk_gen u_clk (.clk(clk));

    mem_stage_top uut (.*);

    wb_mem_model u_mem (.*);

    bind mem_stage_top mem_stage_properties u_props (.*);

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t expect_load(input word_t w, input dm_sel_t sel,
                                          input logic [1:0] lane);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[8*lane +: 8];
        h = lane[1] ? w[31:16] : w[15:0];
        case (sel)
            DM_LB:   return {{24{b[7]}}, b};
            DM_LBU:  return {24'h0, b};
            DM_LH:   return {{16{h[15]}}, h};
            DM_LHU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    function automatic word_t merge_store(input word_t old, input dm_sel_t sel,
                                          input logic [1:0] lane, input word_t wd);
        word_t r;
        r = old;
        case (sel)
            DM_SB:   r[8*lane +: 8] = wd[7:0];
            DM_SH:   r[16*lane[1] +: 16] = wd[15:0];
            default: r = wd;
        endcase
        return r;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic access(input logic ld, input logic st, input logic irq, input logic ov,
                          input dm_sel_t sel, input word_t va, input word_t wd);
        int start;
        @(posedge clk);
        #1;
        req_valid   = 1'b1;
        is_load     = ld;
        is_store    = st;
        interrupt   = irq;
        overflow    = ov;
        dm_sel      = sel;
        vaddr       = va;
        wdata       = wd;
        start       = bus_cycles;
        wait_cycles = 0;
        @(negedge clk);
        while (!done) begin
            wait_cycles++;
            @(negedge clk);
        end
        bus_used = bus_cycles - start;
    endtask

    task automatic finish_req();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        interrupt = 1'b0;
        overflow  = 1'b0;
    endtask

    task automatic load_check(input dm_sel_t sel, input word_t va, input logic want_hit);
        word_t exp;
        access(1'b1, 1'b0, 1'b0, 1'b0, sel, va, '0);
        exp = expect_load(shadow[va[9:2]], sel, va[1:0]);
        assert (!exception && rdata == exp) else stop_with_failure($sformatf(
            "Error at %0t ns: load kind %0d at %08h gave %08h (exc %0b), expected %08h",
            $time, sel, va, rdata, exception, exp));
        if (want_hit) begin
            assert (wait_cycles == 1 && bus_used == 0) else stop_with_failure($sformatf(
                "Error at %0t ns: repeated load at %08h took %0d cycles and %0d bus cycles",
                $time, va, wait_cycles, bus_used));
        end
        if (va[31:29] == UNCACHED_SEG) begin
            assert (bus_used == 1) else stop_with_failure($sformatf(
                "Error at %0t ns: uncached load at %08h made %0d bus cycles",
                $time, va, bus_used));
        end
        finish_req();
    endtask

    // write-through means one bus cycle per store
    task automatic store_check(input dm_sel_t sel, input word_t va, input word_t wd);
        access(1'b0, 1'b1, 1'b0, 1'b0, sel, va, wd);
        assert (!exception && bus_used == 1) else stop_with_failure($sformatf(
            "Error at %0t ns: store to %08h made %0d bus cycles (exc %0b)",
            $time, va, bus_used, exception));
        shadow[va[9:2]] = merge_store(shadow[va[9:2]], sel, va[1:0], wd);
        finish_req();
    endtask

    task automatic fault_check(input logic ld, input logic st, input logic irq, input logic ov,
                               input dm_sel_t sel, input word_t va, input exc_code_t code);
        word_t bad;
        bad = (code == EXC_INT || code == EXC_OV) ? 32'h0 : va;
        access(ld, st, irq, ov, sel, va, '0);
        assert (exception && exc_code == code && badvaddr == bad &&
                wait_cycles == 1) else stop_with_failure($sformatf(
            "Error at %0t ns: fault at %08h gave code %0d bad %08h in %0d cycles, want %0d %08h",
            $time, va, exc_code, badvaddr, wait_cycles, code, bad));
        finish_req();
    endtask

    always @(posedge clk) begin
        if (!rst && wb_cyc && wb_ack) begin
            bus_cycles <= bus_cycles + 1;
            ack_delay  <= 2'(rand_bits(2));
        end
    end

    always @(negedge clk) begin
        if (uut.u_props.fail_count != 0) begin
            stop_with_failure("a bound assertion on the DUT failed");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stop_with_failure("timeout, the DUT stopped answering requests");
    end

    initial begin
        word_t      base;
        word_t      off;
        logic [1:0] lane;
        rst        = 1'b1;
        req_valid  = 1'b0;
        is_load    = 1'b0;
        is_store   = 1'b0;
        overflow   = 1'b0;
        prior_exc  = 1'b0;
        interrupt  = 1'b0;
        dm_sel     = DM_LW;
        vaddr      = '0;
        wdata      = '0;
        pc         = 32'hbfc0_0200;
        prior_code = '0;
        @(posedge clk);
        shadow = u_mem.mem;
        repeat (9) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int r = 0; r < ROUNDS; r++) begin
            base = (rand_bits(1) != 0) ? 32'h8000_0000 : 32'h0000_0000;
            off  = rand_bits(7) << 2;   // cached words stay below 0x200
            lane = 2'(rand_bits(2));
            store_check(DM_SW, base | off, rand_bits(32));
            load_check(DM_LW, base | off, 1'b0);
            load_check(DM_LW, base | off, 1'b1);
            store_check(DM_SB, base | off | lane, rand_bits(32));
            load_check(DM_LB, base | off | lane, 1'b1);
            load_check(DM_LBU, base | off | lane, 1'b1);

            off = 32'h200 | (rand_bits(7) << 2);   // uncached words
            store_check(DM_SH, 32'ha000_0000 | off | {lane[1], 1'b0}, rand_bits(32));
            load_check(DM_LH, 32'ha000_0000 | off | {lane[1], 1'b0}, 1'b0);
            load_check(DM_LHU, 32'ha000_0000 | off | {lane[1], 1'b0}, 1'b0);
            load_check(DM_LW, 32'ha000_0000 | off, 1'b0);

            access(1'b0, 1'b0, 1'b0, 1'b0, DM_LW, base | off, '0);
            assert (!exception && wait_cycles == 1) else stop_with_failure(
                $sformatf("Error at %0t ns: idle request took %0d cycles",
                          $time, wait_cycles));
            finish_req();

            fault_check(1'b1, 1'b0, 1'b1, 1'b1, DM_LW, base | off, EXC_INT);
            fault_check(1'b0, 1'b1, 1'b0, 1'b1, DM_SW, base | off, EXC_OV);
            fault_check(1'b0, 1'b1, 1'b0, 1'b0, DM_SH, base | off | 32'd1, EXC_ADES);
            fault_check(1'b0, 1'b1, 1'b0, 1'b0, DM_SW, base | off | 32'd2, EXC_ADES);
            fault_check(1'b1, 1'b0, 1'b0, 1'b0, DM_LH, base | off | 32'd3, EXC_ADEL);
            fault_check(1'b1, 1'b0, 1'b0, 1'b0, DM_LHU, base | off | 32'd1, EXC_ADEL);
            fault_check(1'b1, 1'b0, 1'b0, 1'b0, DM_LW, 32'ha000_0000 | off | 32'd2, EXC_ADEL);
        end

        repeat (3) @(posedge clk);
        if (uut.u_props.fail_count != 0) begin
            stop_with_failure("a bound assertion on the DUT failed");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// ==== dv/wb_mem_model.sv ====
`timescale 1ns/1ps

module wb_mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  mem_stage_pkg::word_t  wb_adr,
    input  mem_stage_pkg::word_t  wb_dat_w,
    input  mem_stage_pkg::wstrb_t wb_sel,
    input  logic [1:0]            ack_delay,   // wait states for the next cycle
    output mem_stage_pkg::word_t  wb_dat_r,
    output logic                  wb_ack
);
    import mem_stage_pkg::*;

    word_t      mem [256];   // 1 KiB window, upper bits alias
    logic [1:0] wait_cnt;
    logic [7:0] idx;

    assign idx = wb_adr[9:2];

    initial begin
        word_t a;
        for (int i = 0; i < 256; i++) begin
            a      = i << 2;
            mem[i] = (a * 32'h9e37_79b9) ^ 32'h5c3a_81f7;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            wb_ack   <= 1'b0;
            wait_cnt <= 2'd0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                wb_ack   <= 1'b1;
                wb_dat_r <= mem[idx];
                for (int i = 0; i < 4; i++) begin
                    if (wb_we && wb_sel[i]) begin
                        mem[idx][8*i +: 8] <= wb_dat_w[8*i +: 8];
                    end
                end
            end
        end else begin
            wb_ack   <= 1'b0;   // strobes drop the cycle after ack
            wait_cnt <= ack_delay;
        end
    end

endmodule

// ==== hw/dcache_lite.sv ====
`timescale 1ns/1ps

module dcache_lite (
    input  logic      clk,
    input  logic      rst,
    mem_req_if.slave  cache_if,
    mem_req_if.master fill_if
);
    import mem_stage_pkg::*;

    word_t               data_mem [DC_LINES];
    logic [DC_TAG_W-1:0] tag_mem  [DC_LINES];
    logic [DC_LINES-1:0] valid;

    logic [DC_IDX_W-1:0] idx;
    logic [DC_TAG_W-1:0] tag;
    logic                hit;
    logic                busy;       // fill_if cycle outstanding
    logic                hit_ok;
    logic                accept;
    logic                fill_done;
    word_t               hit_rdata;
    word_t               merged;

    assign idx = cache_if.addr[DC_IDX_W+1:2];
    assign tag = cache_if.addr[31:DC_IDX_W+2];
    assign hit = valid[idx] && (tag_mem[idx] == tag);

    // data_ok high means the held request was just answered
    assign accept    = cache_if.req && !cache_if.data_ok && !busy;
    assign fill_done = busy && fill_if.data_ok;

    always_comb begin
        merged = data_mem[idx];
        for (int i = 0; i < 4; i++) begin
            if (cache_if.wstrb[i]) begin
                merged[8*i +: 8] = cache_if.wdata[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy   <= 1'b0;
            hit_ok <= 1'b0;
            valid  <= '0;
        end else begin
            hit_ok <= accept && !cache_if.we && hit;
            if (accept && (cache_if.we || !hit)) begin
                busy <= 1'b1;
            end else if (fill_done) begin
                busy <= 1'b0;
            end
            if (fill_done && !cache_if.we) begin
                valid[idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hit_rdata <= data_mem[idx];
        end
        if (fill_done) begin
            if (!cache_if.we) begin
                data_mem[idx] <= fill_if.rdata;   // refill
                tag_mem[idx]  <= tag;
            end else if (hit) begin
                data_mem[idx] <= merged;          // keep line coherent, no allocate
            end
        end
    end

    // miss data goes straight back, no extra cycle
    assign cache_if.data_ok = hit_ok || fill_done;
    assign cache_if.rdata   = fill_done ? fill_if.rdata : hit_rdata;

    assign fill_if.req   = busy;
    assign fill_if.we    = cache_if.we;
    assign fill_if.addr  = cache_if.addr;
    assign fill_if.wdata = cache_if.wdata;
    assign fill_if.wstrb = cache_if.wstrb;

endmodule

// ==== hw/load_align.sv ====
`timescale 1ns/1ps

module load_align (
    input  mem_stage_pkg::word_t word,
    input  mem_stage_pkg::rext_t rext,
    output mem_stage_pkg::word_t value
);
    import mem_stage_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        sext;

    assign byte_sel = word[8*rext[1:0] +: 8];
    assign half_sel = rext[1] ? word[31:16] : word[15:0];
    assign sext     = rext[3];

    always_comb begin
        if (rext == REXT_WORD) begin
            value = word;
        end else if (rext[2]) begin
            value = {{16{sext && half_sel[15]}}, half_sel};   // lh / lhu
        end else begin
            value = {{24{sext && byte_sel[7]}}, byte_sel};    // lb / lbu
        end
    end

endmodule

// ==== hw/mem_access_prep.sv ====
`timescale 1ns/1ps

module mem_access_prep (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic                   exception,
    input  mem_stage_pkg::dm_sel_t dm_sel,
    input  mem_stage_pkg::word_t   vaddr,
    input  mem_stage_pkg::word_t   wdata,
    output mem_stage_pkg::rext_t   rext,
    output logic                   ack_noop,
    mem_req_if.master              cache_if,
    mem_req_if.master              unc_if
);
    import mem_stage_pkg::*;

    word_t  paddr;
    word_t  wdata_rep;
    wstrb_t strb;
    logic   uncached;
    logic   access;

    assign paddr    = {3'b000, vaddr[28:0]};
    assign uncached = (vaddr[31:29] == UNCACHED_SEG);
    assign access   = req_valid && (is_load || is_store) && !exception;

    always_comb begin
        case (dm_sel)
            DM_SB: begin
                strb      = 4'b0001 << vaddr[1:0];
                wdata_rep = {4{wdata[7:0]}};
            end
            DM_SH: begin
                strb      = vaddr[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{wdata[15:0]}};
            end
            default: begin   // sw and all loads
                strb      = 4'b1111;
                wdata_rep = wdata;
            end
        endcase
    end

    always_comb begin
        case (dm_sel)
            DM_LBU:  rext = {2'b00, vaddr[1:0]};
            DM_LB:   rext = {2'b10, vaddr[1:0]};
            DM_LHU:  rext = {2'b01, vaddr[1], 1'b0};
            DM_LH:   rext = {2'b11, vaddr[1], 1'b0};
            default: rext = REXT_WORD;
        endcase
    end

    assign cache_if.req   = access && !uncached;
    assign cache_if.we    = is_store;
    assign cache_if.addr  = paddr;
    assign cache_if.wdata = wdata_rep;
    assign cache_if.wstrb = strb;

    assign unc_if.req   = access && uncached;
    assign unc_if.we    = is_store;
    assign unc_if.addr  = paddr;
    assign unc_if.wdata = wdata_rep;
    assign unc_if.wstrb = strb;

    // single pulse, request is still held in the pulse cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_noop <= 1'b0;
        end else begin
            ack_noop <= req_valid && (exception || !(is_load || is_store)) && !ack_noop;
        end
    end

endmodule

// ==== hw/mem_bus_master.sv ====
`timescale 1ns/1ps

module mem_bus_master (
    input  logic                  clk,
    input  logic                  rst,
    mem_req_if.slave              fill_if,
    mem_req_if.slave              unc_if,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    output logic                  wb_we,
    output mem_stage_pkg::word_t  wb_adr,
    output mem_stage_pkg::word_t  wb_dat_w,
    output mem_stage_pkg::wstrb_t wb_sel,
    input  mem_stage_pkg::word_t  wb_dat_r,
    input  logic                  wb_ack
);
    import mem_stage_pkg::*;

    bus_state_t state;
    logic       unc_owner;   // uncached path owns the cycle
    logic       we_r;
    logic       fill_ok;
    logic       unc_ok;
    logic       fill_pend;
    logic       unc_pend;
    word_t      rdata_r;

    assign fill_pend = fill_if.req && !fill_if.data_ok;
    assign unc_pend  = unc_if.req && !unc_if.data_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= BUS_IDLE;
            unc_owner <= 1'b0;
            fill_ok   <= 1'b0;
            unc_ok    <= 1'b0;
        end else begin
            fill_ok <= 1'b0;
            unc_ok  <= 1'b0;
            case (state)
                BUS_IDLE: begin
                    if (fill_pend || unc_pend) begin
                        state     <= BUS_WAIT;
                        unc_owner <= !fill_pend;
                    end
                end
                BUS_WAIT: begin
                    if (wb_ack) begin
                        state   <= BUS_IDLE;
                        fill_ok <= !unc_owner;
                        unc_ok  <= unc_owner;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // bus fields frozen once the cycle starts
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE) begin
            we_r     <= fill_pend ? fill_if.we    : unc_if.we;
            wb_adr   <= fill_pend ? fill_if.addr  : unc_if.addr;
            wb_dat_w <= fill_pend ? fill_if.wdata : unc_if.wdata;
            wb_sel   <= fill_pend ? fill_if.wstrb : unc_if.wstrb;
        end
        if (state == BUS_WAIT && wb_ack) begin
            rdata_r <= wb_dat_r;
        end
    end

    assign wb_cyc = (state == BUS_WAIT);
    assign wb_stb = wb_cyc;
    assign wb_we  = wb_cyc && we_r;

    assign fill_if.data_ok = fill_ok;
    assign fill_if.rdata   = rdata_r;
    assign unc_if.data_ok  = unc_ok;
    assign unc_if.rdata    = rdata_r;

endmodule

// ==== hw/mem_exception.sv ====
`timescale 1ns/1ps

module mem_exception (
    input  logic                     req_valid,
    input  logic                     is_load,
    input  logic                     is_store,
    input  logic                     overflow,
    input  logic                     prior_exc,
    input  logic                     interrupt,
    input  mem_stage_pkg::dm_sel_t   dm_sel,
    input  mem_stage_pkg::word_t     vaddr,
    input  mem_stage_pkg::word_t     pc,
    input  mem_stage_pkg::exc_code_t prior_code,
    output logic                     exception,
    output mem_stage_pkg::exc_code_t exc_code,
    output mem_stage_pkg::word_t     badvaddr
);
    import mem_stage_pkg::*;

    logic ov_exc;
    logic ades;
    logic adel;

    // local checks only count when nothing came in from earlier stages
    assign ov_exc = overflow && !prior_exc;
    assign ades = is_store && !prior_exc &&
                  ((dm_sel == DM_SW && vaddr[1:0] != 2'b00) ||
                   (dm_sel == DM_SH && vaddr[0]));
    assign adel = is_load && !prior_exc &&
                  ((dm_sel == DM_LW && vaddr[1:0] != 2'b00) ||
                   ((dm_sel == DM_LH || dm_sel == DM_LHU) && vaddr[0]));

    assign exception = req_valid && (interrupt || ov_exc || ades || adel || prior_exc);

    always_comb begin
        if (interrupt) begin
            exc_code = EXC_INT;
            badvaddr = '0;
        end else if (ov_exc) begin
            exc_code = EXC_OV;
            badvaddr = '0;
        end else if (ades) begin
            exc_code = EXC_ADES;
            badvaddr = vaddr;
        end else if (adel) begin
            exc_code = EXC_ADEL;
            badvaddr = vaddr;
        end else begin
            exc_code = prior_code;   // fetch side error etc
            badvaddr = pc;
        end
    end

endmodule

// ==== hw/mem_req_if.sv ====
`timescale 1ns/1ps

interface mem_req_if;
    import mem_stage_pkg::*;

    logic   req;
    logic   we;
    word_t  addr;      // physical
    word_t  wdata;
    wstrb_t wstrb;
    word_t  rdata;
    logic   data_ok;   // one cycle per request

    modport master (
        output req, we, addr, wdata, wstrb,
        input  rdata, data_ok
    );

    modport slave (
        input  req, we, addr, wdata, wstrb,
        output rdata, data_ok
    );

endinterface

// ==== hw/mem_stage_pkg.sv ====
package mem_stage_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [2:0]  dm_sel_t;
    typedef logic [3:0]  wstrb_t;
    typedef logic [3:0]  rext_t;   // sign, half, lane[1:0]

    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_OV   = 5'd12;

    // stores first, then loads
    localparam dm_sel_t DM_SB  = 3'b000;
    localparam dm_sel_t DM_SH  = 3'b001;
    localparam dm_sel_t DM_SW  = 3'b010;
    localparam dm_sel_t DM_LBU = 3'b011;
    localparam dm_sel_t DM_LB  = 3'b100;
    localparam dm_sel_t DM_LHU = 3'b101;
    localparam dm_sel_t DM_LH  = 3'b110;
    localparam dm_sel_t DM_LW  = 3'b111;

    localparam rext_t REXT_WORD = 4'b1111;

    localparam logic [2:0] UNCACHED_SEG = 3'b101;   // kseg1

    localparam int DC_LINES = 16;
    localparam int DC_IDX_W = $clog2(DC_LINES);
    localparam int DC_TAG_W = 30 - DC_IDX_W;   // word lines, no offset bits

    typedef enum logic {
        BUS_IDLE,
        BUS_WAIT
    } bus_state_t;

endpackage

// ==== hw/mem_stage_top.sv ====
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  logic                     is_load,
    input  logic                     is_store,
    input  logic                     overflow,
    input  logic                     prior_exc,
    input  logic                     interrupt,
    input  mem_stage_pkg::dm_sel_t   dm_sel,
    input  mem_stage_pkg::word_t     vaddr,
    input  mem_stage_pkg::word_t     wdata,
    input  mem_stage_pkg::word_t     pc,
    input  mem_stage_pkg::exc_code_t prior_code,
    output logic                     done,
    output logic                     exception,
    output mem_stage_pkg::exc_code_t exc_code,
    output mem_stage_pkg::word_t     badvaddr,
    output mem_stage_pkg::word_t     rdata,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output mem_stage_pkg::word_t     wb_adr,
    output mem_stage_pkg::word_t     wb_dat_w,
    output mem_stage_pkg::wstrb_t    wb_sel,
    input  mem_stage_pkg::word_t     wb_dat_r,
    input  logic                     wb_ack
);
    import mem_stage_pkg::*;

    rext_t rext;
    logic  ack_noop;
    word_t raw_word;

    mem_req_if cache_if ();
    mem_req_if fill_if ();
    mem_req_if unc_if ();

    mem_exception u_exc (
        .req_valid (req_valid),
        .is_load   (is_load),
        .is_store  (is_store),
        .overflow  (overflow),
        .prior_exc (prior_exc),
        .interrupt (interrupt),
        .dm_sel    (dm_sel),
        .vaddr     (vaddr),
        .pc        (pc),
        .prior_code(prior_code),
        .exception (exception),
        .exc_code  (exc_code),
        .badvaddr  (badvaddr)
    );

    mem_access_prep u_prep (
        .clk      (clk),
        .rst      (rst),
        .req_valid(req_valid),
        .is_load  (is_load),
        .is_store (is_store),
        .exception(exception),
        .dm_sel   (dm_sel),
        .vaddr    (vaddr),
        .wdata    (wdata),
        .rext     (rext),
        .ack_noop (ack_noop),
        .cache_if (cache_if.master),
        .unc_if   (unc_if.master)
    );

    dcache_lite u_dcache (
        .clk     (clk),
        .rst     (rst),
        .cache_if(cache_if.slave),
        .fill_if (fill_if.master)
    );

    mem_bus_master u_bus (
        .clk     (clk),
        .rst     (rst),
        .fill_if (fill_if.slave),
        .unc_if  (unc_if.slave),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_sel  (wb_sel),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack)
    );

    // only one path answers per request
    assign raw_word = unc_if.data_ok ? unc_if.rdata : cache_if.rdata;

    load_align u_align (
        .word (raw_word),
        .rext (rext),
        .value(rdata)
    );

    assign done = ack_noop || cache_if.data_ok || unc_if.data_ok;

endmodule

// ==== tb.f ====
hw/mem_stage_pkg.sv
hw/mem_req_if.sv
hw/mem_exception.sv
hw/mem_access_prep.sv
hw/dcache_lite.sv
hw/mem_bus_master.sv
hw/load_align.sv
hw/mem_stage_top.sv
dv/tb_clk_gen.sv
dv/wb_mem_model.sv
dv/mem_stage_properties.sv
dv/tb_top.sv
